/* eci_cmd_pkg.sv */
package eci_cmd_pkg;

   // Link word and cache line geometry
   localparam int ECI_WORD_WIDTH = 64;
   localparam int ECI_CL_WIDTH = 1024;
   localparam int ECI_CL_ADDR_LSB = 7;
   localparam int ECI_ADDR_WIDTH = 40;
   localparam int ECI_ID_WIDTH = 5;

   // Header word plus 16 data words
   localparam int ECI_PACKET_SIZE = 17;
   localparam int ECI_PACKET_SIZE_WIDTH = 5;

   // Four sub-cache-lines of 32 bytes, four words each
   localparam int ECI_STRB_WIDTH = ECI_CL_WIDTH / 8;
   localparam int ECI_SCL_COUNT = 4;
   localparam int ECI_SCL_STRB = ECI_STRB_WIDTH / ECI_SCL_COUNT;
   localparam int ECI_SCL_WORDS = (ECI_PACKET_SIZE - 1) / ECI_SCL_COUNT;
   localparam int ECI_LINE_WIDTH = ECI_ADDR_WIDTH - ECI_CL_ADDR_LSB;

   // Memory request, write with strobes
   localparam logic [4:0] ECI_CMD_MREQ_RSTT = 5'b01100;

   typedef logic [ECI_WORD_WIDTH-1:0] eci_word_t;

   typedef struct packed {
      logic [4:0]                opcode;
      logic [ECI_ID_WIDTH-1:0]   rreq_id;
      logic [ECI_SCL_COUNT-1:0]  dmask;
      logic                      ns;
      logic [8:0]                reserved;
      logic [ECI_ADDR_WIDTH-1:0] address;
   } eci_rstt_t;

   // Word 0 is the header
   typedef eci_word_t [ECI_PACKET_SIZE-1:0] eci_pkt_t;

   // Low three index bits folded with the next three
   function automatic logic [ECI_LINE_WIDTH-1:0] eci_alias_line(
      input logic [ECI_LINE_WIDTH-1:0] line
   );
      logic [ECI_LINE_WIDTH-1:0] aliased;
      aliased = line;
      aliased[2:0] = line[2:0] ^ line[5:3];
      return aliased;
   endfunction

   // One bit per sub-cache-line with any byte enabled
   function automatic logic [ECI_SCL_COUNT-1:0] eci_dmask_from_strb(
      input logic [ECI_STRB_WIDTH-1:0] strb
   );
      logic [ECI_SCL_COUNT-1:0] dmask;
      for (int s = 0; s < ECI_SCL_COUNT; s++) begin
         dmask[s] = |strb[s*ECI_SCL_STRB +: ECI_SCL_STRB];
      end
      return dmask;
   endfunction

   function automatic eci_word_t eci_wr_hdr(
      input logic [ECI_ADDR_WIDTH-1:0] addr,
      input logic [ECI_ID_WIDTH-1:0]   id,
      input logic [ECI_STRB_WIDTH-1:0] strb
   );
      eci_rstt_t hdr;
      hdr = '0;
      hdr.opcode = ECI_CMD_MREQ_RSTT;
      hdr.rreq_id = id;
      hdr.dmask = eci_dmask_from_strb(strb);
      // Non-secure access
      hdr.ns = 1'b1;
      // Aliased line index back at bit 7, byte offset cleared
      hdr.address = {eci_alias_line(addr[ECI_ADDR_WIDTH-1:ECI_CL_ADDR_LSB]),
                     {ECI_CL_ADDR_LSB{1'b0}}};
      return eci_word_t'(hdr);
   endfunction

   // Highest active sub-cache-line sets the length, never below one
   function automatic logic [ECI_PACKET_SIZE_WIDTH-1:0] eci_size_from_strb(
      input logic [ECI_STRB_WIDTH-1:0] strb
   );
      logic [ECI_SCL_COUNT-1:0] dmask;
      int size;
      dmask = eci_dmask_from_strb(strb);
      size = ECI_PACKET_SIZE - (ECI_SCL_COUNT - 1) * ECI_SCL_WORDS;
      // Ascending scan so the top set bit wins
      for (int s = 0; s < ECI_SCL_COUNT; s++) begin
         if (dmask[s]) begin
            size = ECI_PACKET_SIZE - (ECI_SCL_COUNT - 1 - s) * ECI_SCL_WORDS;
         end
      end
      return ECI_PACKET_SIZE_WIDTH'(size);
   endfunction

endpackage

/* axi_wr_pkg.sv */
package axi_wr_pkg;

   // AXI write side widths
   localparam int AXI_ID_WIDTH = 5;
   localparam int AXI_ADDR_WIDTH = 40;
   localparam int AXI_STRB_WIDTH = 128;
   // One full cache line per beat
   localparam int AXI_DATA_WIDTH = AXI_STRB_WIDTH * 8;

   // Address beat as buffered in a lane
   typedef struct packed {
      logic [AXI_ID_WIDTH-1:0]   id;
      logic [AXI_ADDR_WIDTH-1:0] addr;
   } axi_aw_t;

   // Data beat with its byte enables
   typedef struct packed {
      logic [AXI_DATA_WIDTH-1:0] data;
      logic [AXI_STRB_WIDTH-1:0] strb;
   } axi_w_t;

endpackage

/* wr_req_fifo.sv */
module wr_req_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  FIFO_DEPTH = 4
) (
   input  logic     aclk,
   input  logic     aresetn,
   input  payload_t in_data,
   input  logic     in_valid,
   output logic     in_ready,
   output payload_t out_data,
   output logic     out_valid,
   input  logic     out_ready
);

   localparam int PTR_WIDTH = $clog2(FIFO_DEPTH);

   payload_t mem [FIFO_DEPTH];
   logic [PTR_WIDTH-1:0] wr_ptr;
   logic [PTR_WIDTH-1:0] rd_ptr;
   // One extra bit to tell full from empty
   logic [PTR_WIDTH:0] count;
   logic push;
   logic pop;

   assign in_ready = (count != (PTR_WIDTH+1)'(FIFO_DEPTH));
   assign out_valid = (count != '0);
   assign push = in_valid & in_ready;
   assign pop = out_valid & out_ready;

   // Head read straight from storage
   assign out_data = mem[rd_ptr];

   always_ff @(posedge aclk) begin
      if (push) begin
         mem[wr_ptr] <= in_data;
      end
   end

   // Pointers wrap naturally, depth is a power of two
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count <= count + (PTR_WIDTH+1)'(push) - (PTR_WIDTH+1)'(pop);
      end
   end

   // Lane offers a beat only once both of its FIFOs have room
   a_no_push_full: assert property (@(posedge aclk) disable iff (!aresetn)
      in_valid |-> in_ready)
      else $error("wr_req_fifo push while full");

   // Lane pops only when both heads hold a beat
   a_no_pop_empty: assert property (@(posedge aclk) disable iff (!aresetn)
      out_ready |-> out_valid)
      else $error("wr_req_fifo pop while empty");

endmodule

/* wr_req_dispatch.sv */
module wr_req_dispatch
   import axi_wr_pkg::*;
#(
   parameter int NUM_LANES = 2
) (
   input  logic                      aclk,
   input  logic                      aresetn,
   input  logic [AXI_ID_WIDTH-1:0]   awid,
   input  logic [AXI_ADDR_WIDTH-1:0] awaddr,
   input  logic [7:0]                awlen,
   input  logic                      awvalid,
   output logic                      awready,
   input  logic [AXI_DATA_WIDTH-1:0] wdata,
   input  logic [AXI_STRB_WIDTH-1:0] wstrb,
   input  logic                      wlast,
   input  logic                      wvalid,
   output logic                      wready,
   output axi_aw_t                   lane_aw [NUM_LANES],
   output axi_w_t                    lane_w [NUM_LANES],
   output logic [NUM_LANES-1:0]      lane_valid,
   input  logic [NUM_LANES-1:0]      lane_ready
);

   logic [AXI_ID_WIDTH-1:0] lane_sel;
   logic [NUM_LANES-1:0] lane_hit;
   logic pair_valid;
   logic target_ready;

   // Lane number is the ID modulo the lane count
   assign lane_sel = AXI_ID_WIDTH'(awid % NUM_LANES);

   // Both halves of the write must be present
   assign pair_valid = awvalid & wvalid;
   assign target_ready = |(lane_hit & lane_ready);

   // AW and W taken together, never one without the other
   assign awready = pair_valid & target_ready;
   assign wready = pair_valid & target_ready;

   // Payload is broadcast, only the target lane sees valid
   always_comb begin
      for (int i = 0; i < NUM_LANES; i++) begin
         lane_hit[i] = (lane_sel == AXI_ID_WIDTH'(i));
         lane_valid[i] = pair_valid & lane_hit[i];
         lane_aw[i].id = awid;
         lane_aw[i].addr = awaddr;
         lane_w[i].data = wdata;
         lane_w[i].strb = wstrb;
      end
   end

   // Single-beat cache line writes only
   a_single_beat: assert property (@(posedge aclk) disable iff (!aresetn)
      (awvalid && awready) |-> (awlen == 8'd0 && wlast))
      else $error("wr_req_dispatch burst write accepted");

endmodule

/* wr_req_packer.sv */
module wr_req_packer
   import axi_wr_pkg::*;
   import eci_cmd_pkg::*;
#(
   parameter int FIFO_DEPTH = 4
) (
   input  logic                             aclk,
   input  logic                             aresetn,
   input  axi_aw_t                          in_aw,
   input  axi_w_t                           in_w,
   input  logic                             in_valid,
   output logic                             in_ready,
   output eci_pkt_t                         pkt,
   output logic [ECI_PACKET_SIZE_WIDTH-1:0] pkt_size,
   output logic                             pkt_valid,
   input  logic                             pkt_ready
);

   axi_aw_t aw_head;
   axi_w_t w_head;
   logic aw_in_ready;
   logic w_in_ready;
   logic aw_head_valid;
   logic w_head_valid;
   logic push;
   logic pop;
   eci_word_t hdr;
   logic [ECI_PACKET_SIZE_WIDTH-1:0] size;

   // Accept only when both buffers have a free slot
   assign in_ready = aw_in_ready & w_in_ready;
   assign push = in_valid & in_ready;

   // Pop the pair when the output slot is free or emptying
   assign pop = aw_head_valid & w_head_valid & (~pkt_valid | pkt_ready);

   // Address beats
   wr_req_fifo #(
      .payload_t  (axi_aw_t),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) aw_fifo_i (
      .aclk      (aclk),
      .aresetn   (aresetn),
      .in_data   (in_aw),
      .in_valid  (push),
      .in_ready  (aw_in_ready),
      .out_data  (aw_head),
      .out_valid (aw_head_valid),
      .out_ready (pop)
   );

   // Data beats
   wr_req_fifo #(
      .payload_t  (axi_w_t),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) w_fifo_i (
      .aclk      (aclk),
      .aresetn   (aresetn),
      .in_data   (in_w),
      .in_valid  (push),
      .in_ready  (w_in_ready),
      .out_data  (w_head),
      .out_valid (w_head_valid),
      .out_ready (pop)
   );

   // RSTT header and length from the heads
   assign hdr = eci_wr_hdr(aw_head.addr, aw_head.id, w_head.strb);
   assign size = eci_size_from_strb(w_head.strb);

   // Packet payload, held while waiting on the arbiter
   always_ff @(posedge aclk) begin
      if (pop) begin
         pkt[0] <= hdr;
         // Data word 1 carries the lowest line bytes
         pkt[ECI_PACKET_SIZE-1:1] <= w_head.data;
         pkt_size <= size;
      end
   end

   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         pkt_valid <= 1'b0;
      end else if (pop) begin
         pkt_valid <= 1'b1;
      end else if (pkt_ready) begin
         pkt_valid <= 1'b0;
      end
   end

   // Packet must hold until the arbiter takes it
   a_pkt_stable: assert property (@(posedge aclk) disable iff (!aresetn)
      (pkt_valid && !pkt_ready) |=> (pkt_valid && $stable(pkt) && $stable(pkt_size)))
      else $error("wr_req_packer packet changed under back-pressure");

endmodule

/* vc_pkt_arbiter.sv */
module vc_pkt_arbiter
   import eci_cmd_pkg::*;
#(
   parameter int  NUM_LANES = 2,
   localparam int VC_WIDTH = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
   input  logic                             aclk,
   input  logic                             aresetn,
   input  eci_pkt_t                         lane_pkt [NUM_LANES],
   input  logic [ECI_PACKET_SIZE_WIDTH-1:0] lane_size [NUM_LANES],
   input  logic [NUM_LANES-1:0]             lane_pkt_valid,
   output logic [NUM_LANES-1:0]             lane_pkt_ready,
   output eci_pkt_t                         vc_pkt,
   output logic [ECI_PACKET_SIZE_WIDTH-1:0] vc_pkt_size,
   output logic [VC_WIDTH-1:0]              vc_pkt_vc,
   output logic                             vc_pkt_valid,
   input  logic                             vc_pkt_ready
);

   logic [VC_WIDTH-1:0] last_lane;
   logic [VC_WIDTH-1:0] grant_lane;
   logic grant_valid;
   logic load;

   // First valid lane after the last granted one
   always_comb begin
      int idx;
      grant_valid = 1'b0;
      grant_lane = last_lane;
      for (int off = 1; off <= NUM_LANES; off++) begin
         idx = (int'(last_lane) + off) % NUM_LANES;
         if (!grant_valid && lane_pkt_valid[idx]) begin
            grant_valid = 1'b1;
            grant_lane = VC_WIDTH'(idx);
         end
      end
   end

   // Output slot free or emptying this cycle
   assign load = grant_valid & (~vc_pkt_valid | vc_pkt_ready);

   always_comb begin
      for (int i = 0; i < NUM_LANES; i++) begin
         lane_pkt_ready[i] = load & (grant_lane == VC_WIDTH'(i));
      end
   end

   // Winner payload, lane number travels as the VC
   always_ff @(posedge aclk) begin
      if (load) begin
         vc_pkt <= lane_pkt[grant_lane];
         vc_pkt_size <= lane_size[grant_lane];
         vc_pkt_vc <= grant_lane;
      end
   end

   // Pointer starts on the top lane so lane 0 goes first
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         vc_pkt_valid <= 1'b0;
         last_lane <= VC_WIDTH'(NUM_LANES - 1);
      end else if (load) begin
         vc_pkt_valid <= 1'b1;
         last_lane <= grant_lane;
      end else if (vc_pkt_ready) begin
         vc_pkt_valid <= 1'b0;
      end
   end

   // Only one lane drained per cycle
   a_one_grant: assert property (@(posedge aclk) disable iff (!aresetn)
      $onehot0(lane_pkt_ready))
      else $error("vc_pkt_arbiter granted more than one lane");

endmodule

/* axi_eci_wr_bridge.sv */
module axi_eci_wr_bridge
   import axi_wr_pkg::*;
   import eci_cmd_pkg::*;
#(
   parameter int  NUM_LANES = 2,
   parameter int  FIFO_DEPTH = 4,
   localparam int VC_WIDTH = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
   input  logic                             aclk,
   input  logic                             aresetn,
   input  logic [AXI_ID_WIDTH-1:0]          awid,
   input  logic [AXI_ADDR_WIDTH-1:0]        awaddr,
   input  logic [7:0]                       awlen,
   input  logic                             awvalid,
   output logic                             awready,
   input  logic [AXI_DATA_WIDTH-1:0]        wdata,
   input  logic [AXI_STRB_WIDTH-1:0]        wstrb,
   input  logic                             wlast,
   input  logic                             wvalid,
   output logic                             wready,
   output eci_pkt_t                         vc_pkt,
   output logic [ECI_PACKET_SIZE_WIDTH-1:0] vc_pkt_size,
   output logic [VC_WIDTH-1:0]              vc_pkt_vc,
   output logic                             vc_pkt_valid,
   input  logic                             vc_pkt_ready
);

   // Dispatcher to lanes
   axi_aw_t lane_aw [NUM_LANES];
   axi_w_t lane_w [NUM_LANES];
   logic [NUM_LANES-1:0] lane_valid;
   logic [NUM_LANES-1:0] lane_ready;

   // Lanes to arbiter
   eci_pkt_t lane_pkt [NUM_LANES];
   logic [ECI_PACKET_SIZE_WIDTH-1:0] lane_size [NUM_LANES];
   logic [NUM_LANES-1:0] lane_pkt_valid;
   logic [NUM_LANES-1:0] lane_pkt_ready;

   wr_req_dispatch #(
      .NUM_LANES (NUM_LANES)
   ) dispatch_i (
      .aclk       (aclk),
      .aresetn    (aresetn),
      .awid       (awid),
      .awaddr     (awaddr),
      .awlen      (awlen),
      .awvalid    (awvalid),
      .awready    (awready),
      .wdata      (wdata),
      .wstrb      (wstrb),
      .wlast      (wlast),
      .wvalid     (wvalid),
      .wready     (wready),
      .lane_aw    (lane_aw),
      .lane_w     (lane_w),
      .lane_valid (lane_valid),
      .lane_ready (lane_ready)
   );

   // One packer per lane
   for (genvar g = 0; g < NUM_LANES; g++) begin : gen_lane
      wr_req_packer #(
         .FIFO_DEPTH (FIFO_DEPTH)
      ) packer_i (
         .aclk      (aclk),
         .aresetn   (aresetn),
         .in_aw     (lane_aw[g]),
         .in_w      (lane_w[g]),
         .in_valid  (lane_valid[g]),
         .in_ready  (lane_ready[g]),
         .pkt       (lane_pkt[g]),
         .pkt_size  (lane_size[g]),
         .pkt_valid (lane_pkt_valid[g]),
         .pkt_ready (lane_pkt_ready[g])
      );
   end

   vc_pkt_arbiter #(
      .NUM_LANES (NUM_LANES)
   ) arbiter_i (
      .aclk           (aclk),
      .aresetn        (aresetn),
      .lane_pkt       (lane_pkt),
      .lane_size      (lane_size),
      .lane_pkt_valid (lane_pkt_valid),
      .lane_pkt_ready (lane_pkt_ready),
      .vc_pkt         (vc_pkt),
      .vc_pkt_size    (vc_pkt_size),
      .vc_pkt_vc      (vc_pkt_vc),
      .vc_pkt_valid   (vc_pkt_valid),
      .vc_pkt_ready   (vc_pkt_ready)
   );

endmodule

/* tb_axi_eci_wr_bridge.sv */
module tb_axi_eci_wr_bridge
   import axi_wr_pkg::*;
   import eci_cmd_pkg::*;
();

   localparam int NUM_LANES = 2;
   localparam int FIFO_DEPTH = 4;
   localparam int LANE_W = 1;
   localparam int NUM_WRITES = 400;
   localparam int TIMEOUT_CYCLES = NUM_WRITES * 8 + 200;
   // Ample for a full pipeline under heavy back-pressure
   localparam int DRAIN_CYCLES = 200;

   // One expected packet with the VC it must leave on
   typedef struct packed {
      eci_pkt_t                         pkt;
      logic [ECI_PACKET_SIZE_WIDTH-1:0] size;
      logic [LANE_W-1:0]                vc;
   } exp_t;

   logic                             aclk;
   logic                             aresetn;
   logic [AXI_ID_WIDTH-1:0]          awid;
   logic [AXI_ADDR_WIDTH-1:0]        awaddr;
   logic [7:0]                       awlen;
   logic                             awvalid;
   logic                             awready;
   logic [AXI_DATA_WIDTH-1:0]        wdata;
   logic [AXI_STRB_WIDTH-1:0]        wstrb;
   logic                             wlast;
   logic                             wvalid;
   logic                             wready;
   eci_pkt_t                         vc_pkt;
   logic [ECI_PACKET_SIZE_WIDTH-1:0] vc_pkt_size;
   logic [LANE_W-1:0]                vc_pkt_vc;
   logic                             vc_pkt_valid;
   logic                             vc_pkt_ready;

   // Per-lane expected packets in acceptance order
   exp_t exp_q [NUM_LANES][$];
   int accepted = 0;
   int cycles = 0;
   bit started = 1'b0;
   bit bp_heavy = 1'b0;

   axi_eci_wr_bridge #(
      .NUM_LANES  (NUM_LANES),
      .FIFO_DEPTH (FIFO_DEPTH)
   ) dut_i (
      .aclk         (aclk),
      .aresetn      (aresetn),
      .awid         (awid),
      .awaddr       (awaddr),
      .awlen        (awlen),
      .awvalid      (awvalid),
      .awready      (awready),
      .wdata        (wdata),
      .wstrb        (wstrb),
      .wlast        (wlast),
      .wvalid       (wvalid),
      .wready       (wready),
      .vc_pkt       (vc_pkt),
      .vc_pkt_size  (vc_pkt_size),
      .vc_pkt_vc    (vc_pkt_vc),
      .vc_pkt_valid (vc_pkt_valid),
      .vc_pkt_ready (vc_pkt_ready)
   );

   initial begin
      aclk = 1'b0;
      forever #20 aclk = ~aclk;
   end

   // Expected RSTT packet worked out from the header layout and size rule
   function automatic exp_t expected_packet(
      input logic [AXI_ID_WIDTH-1:0]   id,
      input logic [AXI_ADDR_WIDTH-1:0] addr,
      input logic [AXI_DATA_WIDTH-1:0] data,
      input logic [AXI_STRB_WIDTH-1:0] strb
   );
      exp_t e;
      logic [3:0] dmask;
      logic [AXI_ADDR_WIDTH-8:0] line;
      // 32 strobe bits per 32-byte sub-cache-line
      for (int s = 0; s < 4; s++) begin
         dmask[s] = |strb[s*32 +: 32];
      end
      // Line index with bits 2..0 folded with bits 5..3
      line = addr[AXI_ADDR_WIDTH-1:7];
      line[2:0] = addr[9:7] ^ addr[12:10];
      e.pkt[0] = {ECI_CMD_MREQ_RSTT, id, dmask, 1'b1, 9'd0, line, 7'd0};
      // Word 1 holds the lowest 8 bytes of the line
      for (int i = 1; i < 17; i++) begin
         e.pkt[i] = data[(i-1)*64 +: 64];
      end
      if (dmask[3]) begin
         e.size = 5'd17;
      end else if (dmask[2]) begin
         e.size = 5'd13;
      end else if (dmask[1]) begin
         e.size = 5'd9;
      end else begin
         e.size = 5'd5;
      end
      e.vc = LANE_W'(int'(id) % NUM_LANES);
      return e;
   endfunction

   // Full, empty, random sub-lines or one single byte
   function automatic logic [AXI_STRB_WIDTH-1:0] random_strobe();
      logic [AXI_STRB_WIDTH-1:0] strb;
      logic [6:0] bit_pos;
      strb = '0;
      case ($urandom_range(0, 3))
         0: strb = '1;
         1: strb = '0;
         2: begin
            for (int s = 0; s < 4; s++) begin
               if ($urandom_range(0, 1) == 1) begin
                  strb[s*32 +: 32] = $urandom() | 32'h1;
               end
            end
         end
         default: begin
            bit_pos = 7'($urandom_range(0, 127));
            strb[bit_pos] = 1'b1;
         end
      endcase
      return strb;
   endfunction

   task automatic check_pkt(input eci_pkt_t exp_pkt, input eci_pkt_t act_pkt);
      int bad;
      bad = -1;
      for (int i = 0; i < ECI_PACKET_SIZE; i++) begin
         if (bad < 0 && act_pkt[i] !== exp_pkt[i]) begin
            bad = i;
         end
      end
      if (bad >= 0) begin
         $display("FAIL vc_pkt word %0d expected %h actual %h", bad, exp_pkt[bad],
                  act_pkt[bad]);
         $display("Testbench failed");
         $fatal(1, "packet mismatch");
      end
   endtask

   task automatic check_size(input logic [ECI_PACKET_SIZE_WIDTH-1:0] exp_size,
                             input logic [ECI_PACKET_SIZE_WIDTH-1:0] act_size);
      if (act_size !== exp_size) begin
         $display("FAIL vc_pkt_size expected %h actual %h", exp_size, act_size);
         $display("Testbench failed");
         $fatal(1, "size mismatch");
      end
   endtask

   task automatic check_vc(input logic [LANE_W-1:0] exp_vc, input logic [LANE_W-1:0] act_vc);
      if (act_vc !== exp_vc) begin
         $display("FAIL vc_pkt_vc expected %h actual %h", exp_vc, act_vc);
         $display("Testbench failed");
         $fatal(1, "VC mismatch");
      end
   endtask

   // One write with independent AW and W start delays
   task automatic send_write();
      logic [AXI_ID_WIDTH-1:0] id;
      logic [AXI_ADDR_WIDTH-1:0] addr;
      logic [AXI_DATA_WIDTH-1:0] data;
      logic [AXI_STRB_WIDTH-1:0] strb;
      int gap;
      int aw_wait;
      int w_wait;
      bit done;
      id = AXI_ID_WIDTH'($urandom_range(0, 31));
      addr = AXI_ADDR_WIDTH'({$urandom(), $urandom()});
      for (int i = 0; i < AXI_DATA_WIDTH / 32; i++) begin
         data[i*32 +: 32] = $urandom();
      end
      strb = random_strobe();
      gap = $urandom_range(0, 2);
      repeat (gap) @(posedge aclk);
      aw_wait = $urandom_range(0, 2);
      w_wait = $urandom_range(0, 2);
      awid <= id;
      awaddr <= addr;
      wdata <= data;
      wstrb <= strb;
      awvalid <= (aw_wait == 0);
      wvalid <= (w_wait == 0);
      done = 1'b0;
      while (!done) begin
         @(posedge aclk);
         if (awvalid && awready && wvalid && wready) begin
            done = 1'b1;
         end else begin
            if (aw_wait > 0) begin
               aw_wait--;
            end
            if (w_wait > 0) begin
               w_wait--;
            end
            if (aw_wait == 0) begin
               awvalid <= 1'b1;
            end
            if (w_wait == 0) begin
               wvalid <= 1'b1;
            end
         end
      end
      awvalid <= 1'b0;
      wvalid <= 1'b0;
   endtask

   // Accepted writes become expected packets on their lane
   always @(posedge aclk) begin
      logic [LANE_W-1:0] lane;
      if (started && accepted == 0 && vc_pkt_valid !== 1'b0) begin
         $display("Packet output went valid before any write was accepted");
         $display("Testbench failed");
         $fatal(1, "early valid");
      end else if (started && awready !== wready) begin
         // AW and W leave the inputs only as a pair
         $display("AW and W were not accepted in the same cycle");
         $display("Testbench failed");
         $fatal(1, "split handshake");
      end else begin
         started = 1'b1;
         if (awvalid && awready && wvalid && wready) begin
            lane = LANE_W'(int'(awid) % NUM_LANES);
            exp_q[lane].push_back(expected_packet(awid, awaddr, wdata, wstrb));
            accepted++;
         end
      end
   end

   // Each output transfer checked against the lane it belongs to
   always @(posedge aclk) begin
      exp_t got;
      int lane;
      if (vc_pkt_valid && vc_pkt_ready) begin
         // Lane whose oldest packet this is, else the lane named by the VC
         lane = int'(vc_pkt_vc);
         for (int l = 0; l < NUM_LANES; l++) begin
            if (exp_q[l].size() != 0 && exp_q[l][0].pkt === vc_pkt) begin
               lane = l;
            end
         end
         if (exp_q[lane].size() == 0) begin
            $display("Packet on VC %0d with no write outstanding for that lane", vc_pkt_vc);
            $display("Testbench failed");
            $fatal(1, "extra packet");
         end else begin
            got = exp_q[lane].pop_front();
            check_vc(got.vc, vc_pkt_vc);
            check_size(got.size, vc_pkt_size);
            check_pkt(got.pkt, vc_pkt);
         end
      end
   end

   // Output back-pressure with light and heavy phases
   always @(posedge aclk) begin
      if ($urandom_range(0, 31) == 0) begin
         bp_heavy <= ~bp_heavy;
      end
      if (bp_heavy) begin
         vc_pkt_ready <= ($urandom_range(0, 3) == 0);
      end else begin
         vc_pkt_ready <= ($urandom_range(0, 3) != 0);
      end
   end

   always @(posedge aclk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("Run did not finish within %0d cycles, %0d of %0d writes accepted",
                  cycles, accepted, NUM_WRITES);
         $display("Testbench failed");
         $fatal(1, "timeout");
      end
   end

   initial begin
      int drain;
      void'($urandom(32'hd5f0_fdc9));
      aresetn = 1'b0;
      awid = '0;
      awaddr = '0;
      awlen = 8'd0;
      awvalid = 1'b0;
      wdata = '0;
      wstrb = '0;
      wlast = 1'b1;
      wvalid = 1'b0;
      vc_pkt_ready = 1'b0;
      repeat (8) @(posedge aclk);
      aresetn <= 1'b1;
      for (int n = 0; n < NUM_WRITES; n++) begin
         send_write();
      end
      // Drain within a bound, then idle a while to catch any extra packet
      drain = 0;
      @(negedge aclk);
      while ((exp_q[0].size() != 0 || exp_q[1].size() != 0) && drain < DRAIN_CYCLES) begin
         @(negedge aclk);
         drain++;
      end
      repeat (20) @(negedge aclk);
      if (exp_q[0].size() == 0 && exp_q[1].size() == 0) begin
         $display("Testbench passed");
         $finish;
      end else begin
         $display("Missing packets, %0d writes accepted, %0d and %0d still expected",
                  accepted, exp_q[0].size(), exp_q[1].size());
         $display("Testbench failed");
         $fatal(1, "missing packets");
      end
   end

endmodule

/* files.f */
eci_cmd_pkg.sv
axi_wr_pkg.sv
wr_req_fifo.sv
wr_req_dispatch.sv
wr_req_packer.sv
vc_pkt_arbiter.sv
axi_eci_wr_bridge.sv
tb_axi_eci_wr_bridge.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_axi_eci_wr_bridge
FILELIST ?= files.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

# Build, run, and decide the result from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
